//--- Bender.yml
package:
  name: umi_fifoflex

sources:
  - verilog/umi_flex_pkg.sv
  - verilog/umi_width_split.sv
  - verilog/umi_sync_fifo.sv
  - verilog/umi_fifoflex.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_umi_fifoflex.sv

//--- sim/tb_umi_model.svh
// Reference split model, expected output queue and xorshift random generators

`ifndef TB_UMI_MODEL_SVH
`define TB_UMI_MODEL_SVH

localparam logic [31:0] RNG_SEED = 32'h3946_98d3;

// Chunks still to be seen on the output, oldest first
umi_out_pkt_t exp_q[$];

// Separate streams for packets and for sink ready
logic [31:0] pkt_state   = RNG_SEED;
logic [31:0] ready_state = {RNG_SEED[15:0], RNG_SEED[31:16]};

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

function automatic logic [31:0] pkt_rand();
   pkt_state = xorshift32(pkt_state);
   return pkt_state;
endfunction

function automatic logic [31:0] ready_rand();
   ready_state = xorshift32(ready_state);
   return ready_state;
endfunction

// ##########################################################################
// Split rule, one output chunk per 8 bytes of payload
// ##########################################################################

function automatic void expect_split(input umi_in_pkt_t pkt);
   int             left;
   int             per_beat;
   int             k;
   logic [AW-1:0]  step;
   logic [IDW-1:0] shifted;
   umi_out_pkt_t   chunk;
   left     = int'(pkt.cmd.len) + 1;
   per_beat = ODW_BYTES / (1 << pkt.cmd.size);
   k        = 0;
   while (left > 0)
   begin
      step          = ODW_BYTES * k;
      shifted       = pkt.data >> (ODW * k);
      chunk.cmd     = pkt.cmd;
      chunk.dstaddr = pkt.dstaddr + step;
      chunk.srcaddr = pkt.srcaddr + step;
      chunk.data    = shifted[ODW-1:0];
      if (left > per_beat)
      begin
         // More to come, so no end of message yet
         chunk.cmd.len = 8'(per_beat - 1);
         chunk.cmd.eom = 1'b0;
         left          = left - per_beat;
      end
      else
      begin
         chunk.cmd.len = 8'(left - 1);
         left          = 0;
      end
      exp_q.push_back(chunk);
      k++;
   end
endfunction

`endif

//--- sim/tb_umi_fifoflex.sv
// Testbench for the UMI width converter: clock, reset, stimulus, output comparison

module tb_umi_fifoflex;

   import umi_flex_pkg::*;

   `include "tb_umi_model.svh"

   localparam int TIMEOUT_CYCLES = 1000;

   logic         umi_in_clk;
   logic         umi_in_nreset;
   logic         bypass;
   logic         umi_in_valid;
   umi_in_pkt_t  umi_in_pkt;
   logic         umi_in_ready;
   logic         umi_out_valid;
   umi_out_pkt_t umi_out_pkt;
   logic         umi_out_ready;
   logic         fifo_full;
   logic         fifo_empty;

   // 0 always ready, 1 random, 2 stalled
   int           ready_mode = 0;
   int           full_cycles;
   logic [31:0]  stream_seed;
   umi_in_pkt_t  pkt;

   umi_fifoflex UUT
     (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .bypass        (bypass),
      .umi_in_valid  (umi_in_valid),
      .umi_in_pkt    (umi_in_pkt),
      .umi_in_ready  (umi_in_ready),
      .umi_out_valid (umi_out_valid),
      .umi_out_pkt   (umi_out_pkt),
      .umi_out_ready (umi_out_ready),
      .fifo_full     (fifo_full),
      .fifo_empty    (fifo_empty)
      );

   initial
   begin
      umi_in_clk = 1'b0;
      forever #50 umi_in_clk = ~umi_in_clk;
   end

   // ########################################################################
   // Helpers
   // ########################################################################

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1, "testbench stopped on error");
   endtask

   task automatic check_val(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
      if (actual !== expected)
         abort_run($sformatf("ERR time %0t %s expected %h actual %h",
                             $time, name, expected, actual));
   endtask

   task automatic next_cycle();
      @(posedge umi_in_clk);
      #10;
   endtask

   // Called just after a drive point, returns after the transfer edge
   task automatic send_pkt(input umi_in_pkt_t p);
      int   waited;
      logic done;
      waited       = 0;
      done         = 1'b0;
      umi_in_valid = 1'b1;
      umi_in_pkt   = p;
      while (!done)
      begin
         @(negedge umi_in_clk);
         if (umi_in_ready)
            done = 1'b1;
         else
         begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
               abort_run("Timed out waiting for the DUT to accept an input packet");
         end
         next_cycle();
      end
      umi_in_valid = 1'b0;
   endtask

   // Ends on a falling edge with nothing left to see
   task automatic wait_idle();
      int waited;
      waited = 0;
      @(negedge umi_in_clk);
      while (exp_q.size() != 0 || umi_out_valid)
      begin
         waited++;
         if (waited > TIMEOUT_CYCLES)
            abort_run("Timed out waiting for the output stream to drain");
         @(negedge umi_in_clk);
      end
   endtask

   task automatic wait_full(output int cycles);
      cycles = 0;
      do
      begin
         @(negedge umi_in_clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            abort_run("Timed out waiting for the FIFO to report full");
      end
      while (!fifo_full);
   endtask

   function automatic umi_in_pkt_t random_pkt();
      umi_in_pkt_t p;
      int          sz;
      int          words;
      p.cmd      = pkt_rand();
      sz         = int'(pkt_rand() % 4);
      // Total payload stays within 256 bytes
      words      = int'(pkt_rand() % (256 >> sz));
      p.cmd.size = 3'(sz);
      p.cmd.len  = 8'(words);
      p.dstaddr  = {pkt_rand(), pkt_rand()};
      p.srcaddr  = {pkt_rand(), pkt_rand()};
      for (int i = 0; i < 8; i++)
         p.data[32*i +: 32] = pkt_rand();
      return p;
   endfunction

   task automatic run_stream(input int count);
      umi_in_pkt_t p;
      for (int i = 0; i < count; i++)
      begin
         p = random_pkt();
         expect_split(p);
         send_pkt(p);
      end
   endtask

   // ########################################################################
   // Sink ready and output comparison
   // ########################################################################

   initial
   begin
      forever
      begin
         next_cycle();
         case (ready_mode)
            0: umi_out_ready = 1'b1;
            1: umi_out_ready = (ready_rand() % 4) != 0;
            default: umi_out_ready = 1'b0;
         endcase
      end
   end

   // Falling edge sees settled values of the coming transfer
   always @(negedge umi_in_clk)
   begin : compare_out
      umi_out_pkt_t exp_pkt;
      if (umi_in_nreset && umi_out_valid && umi_out_ready)
      begin
         if (exp_q.size() == 0)
            abort_run("Output packet appeared with nothing left to expect");
         else
         begin
            exp_pkt = exp_q.pop_front();
            check_val("umi_out_pkt.cmd", 64'(exp_pkt.cmd), 64'(umi_out_pkt.cmd));
            check_val("umi_out_pkt.dstaddr", exp_pkt.dstaddr, umi_out_pkt.dstaddr);
            check_val("umi_out_pkt.srcaddr", exp_pkt.srcaddr, umi_out_pkt.srcaddr);
            check_val("umi_out_pkt.data", exp_pkt.data, umi_out_pkt.data);
         end
      end
      if (umi_in_nreset && bypass)
      begin
         check_val("fifo_empty", 64'd1, 64'(fifo_empty));
         check_val("fifo_full", umi_out_ready ? 64'd0 : 64'd1, 64'(fifo_full));
      end
   end

   // ########################################################################
   // Main sequence
   // ########################################################################

   initial
   begin
      umi_in_nreset = 1'b0;
      bypass        = 1'b0;
      umi_in_valid  = 1'b0;
      umi_in_pkt    = '0;
      umi_out_ready = 1'b0;
      repeat (8) @(posedge umi_in_clk);
      #10;
      umi_in_nreset = 1'b1;

      // State right after reset
      @(negedge umi_in_clk);
      check_val("umi_out_valid", 64'd0, 64'(umi_out_valid));
      check_val("fifo_empty", 64'd1, 64'(fifo_empty));
      check_val("fifo_full", 64'd0, 64'(fifo_full));
      check_val("umi_in_ready", 64'd1, 64'(umi_in_ready));
      next_cycle();

      // Exactly one output beat
      pkt          = random_pkt();
      pkt.cmd.size = 3'd2;
      pkt.cmd.len  = 8'd1;
      expect_split(pkt);
      send_pkt(pkt);
      wait_idle();
      next_cycle();

      // Largest byte packet, then mixed sizes
      pkt          = random_pkt();
      pkt.cmd.size = 3'd0;
      pkt.cmd.len  = 8'd255;
      expect_split(pkt);
      send_pkt(pkt);
      run_stream(12);
      wait_idle();

      // Stalled sink fed exactly FIFO_DEPTH chunks
      // Remainder is empty at full, so input ready reflects the FIFO alone
      ready_mode = 2;
      next_cycle();
      pkt          = random_pkt();
      pkt.cmd.size = 3'd0;
      pkt.cmd.len  = 8'(FIFO_DEPTH * ODW_BYTES - 1);
      expect_split(pkt);
      send_pkt(pkt);
      wait_full(full_cycles);
      check_val("fifo_full cycles", 64'(FIFO_DEPTH), 64'(full_cycles));
      check_val("umi_in_ready", 64'd0, 64'(umi_in_ready));
      check_val("umi_out_valid", 64'd1, 64'(umi_out_valid));
      ready_mode = 0;
      wait_idle();

      // Random sink ready through the FIFO
      ready_mode  = 1;
      stream_seed = pkt_state;
      next_cycle();
      run_stream(40);
      wait_idle();

      // Same packets again with the FIFO bypassed
      next_cycle();
      bypass    = 1'b1;
      pkt_state = stream_seed;
      next_cycle();
      run_stream(40);
      wait_idle();
      next_cycle();
      bypass = 1'b0;
      next_cycle();

      if (exp_q.size() == 0)
      begin
         $display("Simulation PASSED");
         $finish;
      end
      else
         abort_run("Expected output packets were never received");
   end

endmodule

//--- umi_fifoflex.f
+incdir+sim
verilog/umi_flex_pkg.sv
verilog/umi_width_split.sv
verilog/umi_sync_fifo.sv
verilog/umi_fifoflex.sv
sim/tb_umi_fifoflex.sv

//--- verilog/umi_fifoflex.sv
// UMI 256-to-64 bit width converter top: splitter, output FIFO, bypass path and status

module umi_fifoflex
  (
   input  logic                        umi_in_clk,
   input  logic                        umi_in_nreset,
   // Skip the FIFO, only changed while idle
   input  logic                        bypass,
   // Wide input
   input  logic                        umi_in_valid,
   input  umi_flex_pkg::umi_in_pkt_t   umi_in_pkt,
   output logic                        umi_in_ready,
   // Narrow output
   output logic                        umi_out_valid,
   output umi_flex_pkg::umi_out_pkt_t  umi_out_pkt,
   input  logic                        umi_out_ready,
   // Status
   output logic                        fifo_full,
   output logic                        fifo_empty
   );

   import umi_flex_pkg::*;

   // Splitter output
   logic         split_valid;
   logic         split_ready;
   umi_out_pkt_t split_pkt;

   // FIFO side
   logic         fifo_wr;
   logic         fifo_rd;
   logic         fifo_full_raw;
   logic         fifo_empty_raw;
   umi_out_pkt_t fifo_pkt;

   // ########################################################################
   // Splitter
   // ########################################################################

   umi_width_split split_i
     (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .in_valid      (umi_in_valid),
      .in_pkt        (umi_in_pkt),
      .in_ready      (umi_in_ready),
      .out_valid     (split_valid),
      .out_pkt       (split_pkt),
      .out_ready     (split_ready)
      );

   // Back-pressure comes from the sink directly in bypass
   assign split_ready = bypass ? umi_out_ready : ~fifo_full_raw;

   // ########################################################################
   // Output FIFO
   // ########################################################################

   // Nothing is queued while bypassed
   assign fifo_wr = split_valid & split_ready & ~bypass;

   // Pop the head on every output transfer
   assign fifo_rd = umi_out_ready & ~fifo_empty_raw;

   umi_sync_fifo
     #(
       .DEPTH     (FIFO_DEPTH),
       .payload_t (umi_out_pkt_t)
       )
   fifo_i
     (
      .umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .wr_en         (fifo_wr),
      .wr_data       (split_pkt),
      .full          (fifo_full_raw),
      .rd_en         (fifo_rd),
      .rd_data       (fifo_pkt),
      .empty         (fifo_empty_raw)
      );

   // ########################################################################
   // Bypass select and status
   // ########################################################################

   assign umi_out_valid = bypass ? split_valid : ~fifo_empty_raw;
   assign umi_out_pkt   = bypass ? split_pkt   : fifo_pkt;

   // In bypass, full mirrors the sink stall
   assign fifo_full  = bypass ? ~umi_out_ready : fifo_full_raw;
   assign fifo_empty = bypass ? 1'b1           : fifo_empty_raw;

endmodule

//--- verilog/umi_flex_pkg.sv
// UMI bus widths, FIFO depth, command struct and input/output packet structs

package umi_flex_pkg;

   // ########################################################################
   // Bus widths
   // ########################################################################

   localparam int CW = 32;
   localparam int AW = 64;

   // Wide input bus and narrow output bus
   localparam int IDW = 256;
   localparam int ODW = 64;

   // Bytes carried by one output beat
   localparam int ODW_BYTES = ODW / 8;

   // Default number of buffered output chunks
   localparam int FIFO_DEPTH = 4;

   // ########################################################################
   // Command word
   // ########################################################################

   // First member lands in the top bits, so opcode sits at [4:0]
   typedef struct packed {
      logic [4:0] hostid;
      logic [1:0] user;
      logic       ex;
      logic       eof;
      logic       eom;
      logic [1:0] prot;
      logic [3:0] qos;
      // Words in the packet minus one
      logic [7:0] len;
      // Bytes per word are 2**size
      logic [2:0] size;
      logic [4:0] opcode;
   } umi_cmd_t;

   // ########################################################################
   // Packets
   // ########################################################################

   typedef struct packed {
      logic [IDW-1:0] data;
      logic [AW-1:0]  srcaddr;
      logic [AW-1:0]  dstaddr;
      umi_cmd_t       cmd;
   } umi_in_pkt_t;

   typedef struct packed {
      logic [ODW-1:0] data;
      logic [AW-1:0]  srcaddr;
      logic [AW-1:0]  dstaddr;
      umi_cmd_t       cmd;
   } umi_out_pkt_t;

endpackage

//--- verilog/umi_sync_fifo.sv
// Single-clock FIFO with registered full/empty flags and a type-parameterized payload

module umi_sync_fifo
  #(
    // Power of two, at least 2
    parameter int  DEPTH     = umi_flex_pkg::FIFO_DEPTH,
    parameter type payload_t = umi_flex_pkg::umi_out_pkt_t
    )
   (
    input  logic     umi_in_clk,
    input  logic     umi_in_nreset,
    // Write side
    input  logic     wr_en,
    input  payload_t wr_data,
    output logic     full,
    // Read side
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty
    );

   // Storage
   payload_t mem [DEPTH];

   // Pointers wrap naturally at DEPTH
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;

   // Occupancy, one extra bit to hold DEPTH
   logic [$clog2(DEPTH):0]   count;
   logic [$clog2(DEPTH):0]   count_next;

   logic wr_ok;
   logic rd_ok;

   // Blocked accesses are dropped
   assign wr_ok = wr_en & ~full;
   assign rd_ok = rd_en & ~empty;

   always_comb
   begin
      count_next = count;
      if (wr_ok && !rd_ok)
         count_next = count + 1'b1;
      else if (rd_ok && !wr_ok)
         count_next = count - 1'b1;
   end

   // ########################################################################
   // Pointers and status
   // ########################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b0;
         empty  <= 1'b1;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count_next;
         full  <= (count_next == DEPTH);
         empty <= (count_next == 0);
      end
   end

   // ########################################################################
   // Data
   // ########################################################################

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_ok)
         mem[wr_ptr] <= wr_data;
   end

   // Head entry, valid whenever not empty
   assign rd_data = mem[rd_ptr];

endmodule

//--- verilog/umi_width_split.sv
// Splitter cutting wide UMI input packets into output-width chunks via a remainder latch

module umi_width_split
  (
   input  logic                        umi_in_clk,
   input  logic                        umi_in_nreset,
   // Wide side
   input  logic                        in_valid,
   input  umi_flex_pkg::umi_in_pkt_t   in_pkt,
   output logic                        in_ready,
   // Narrow side
   output logic                        out_valid,
   output umi_flex_pkg::umi_out_pkt_t  out_pkt,
   input  logic                        out_ready
   );

   import umi_flex_pkg::*;

   // Remainder of a packet still being cut
   logic        rem_valid;
   umi_in_pkt_t rem_pkt;

   // Packet currently being worked on
   umi_in_pkt_t held;

   logic [8:0]  words_per_beat;
   logic [8:0]  len_plus_one;
   logic        cut;
   logic        beat_done;

   umi_cmd_t    chunk_cmd;
   umi_cmd_t    rem_cmd;
   umi_in_pkt_t next_rem;

   // ########################################################################
   // Source selection and split decision
   // ########################################################################

   // Leftover data always goes first
   assign held = rem_valid ? rem_pkt : in_pkt;

   // Words that fit on the narrow bus for this size
   assign words_per_beat = 9'(ODW_BYTES) >> held.cmd.size;

   assign len_plus_one = {1'b0, held.cmd.len} + 9'd1;

   assign cut = (len_plus_one > words_per_beat);

   // Handshake
   assign out_valid = rem_valid | in_valid;
   assign in_ready  = ~rem_valid & out_ready;
   assign beat_done = out_valid & out_ready;

   // ########################################################################
   // Emitted chunk
   // ########################################################################

   always_comb
   begin
      chunk_cmd = held.cmd;
      if (cut)
      begin
         // Full beat, more to follow
         chunk_cmd.len = words_per_beat[7:0] - 8'd1;
         chunk_cmd.eom = 1'b0;
      end
   end

   assign out_pkt.cmd     = chunk_cmd;
   assign out_pkt.dstaddr = held.dstaddr;
   assign out_pkt.srcaddr = held.srcaddr;
   assign out_pkt.data    = held.data[ODW-1:0];

   // ########################################################################
   // Next remainder
   // ########################################################################

   // Original eom stays with the remainder
   always_comb
   begin
      rem_cmd     = held.cmd;
      rem_cmd.len = held.cmd.len - words_per_beat[7:0];
   end

   assign next_rem.cmd     = rem_cmd;
   assign next_rem.dstaddr = held.dstaddr + AW'(ODW_BYTES);
   assign next_rem.srcaddr = held.srcaddr + AW'(ODW_BYTES);
   assign next_rem.data    = held.data >> ODW;

   // Occupied after a cut, empty once the last chunk leaves
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         rem_valid <= 1'b0;
      else if (beat_done)
         rem_valid <= cut;
   end

   // Remainder contents
   always_ff @(posedge umi_in_clk)
   begin
      if (beat_done && cut)
         rem_pkt <= next_rem;
   end

endmodule
